// File: Makefile
# Verilator build for the branch predictor testbench
VERILATOR ?= verilator
TOP       ?= branch_pred_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
verilog/bp_pkg.sv
verilog/slot_if.sv
verilog/fetch_block_aligner.sv
verilog/slot_predecoder.sv
verilog/gshare_predictor.sv
verilog/return_stack.sv
verilog/next_pc_select.sv
verilog/branch_pred_top.sv
tests/branch_pred_tb.sv

// File: tests/branch_pred_tb.sv
`timescale 1ns/1ps
/* testbench for branch_pred_top. memory answers in request order after 1..4 cycles.
   resolves are issued only while requests are paused after a redirect */
module branch_pred_tb
  import bp_pkg::*;
;

  localparam int SLOTS     = 4;
  localparam int GHR_K     = 8;
  localparam int PHT_N     = 6;
  localparam int RAS_DEPTH = 8;
  localparam int BLOCKS    = 40; // predictions waited for over all tests
  localparam int IDX_W     = GHR_K + PHT_N;

  logic              clk_in;
  logic              rst_N_in;
  logic              redirect_valid;
  logic [PC_W-1:0]   redirect_pc;
  logic              req_ready;
  logic              line_valid;
  logic [LINE_W-1:0] line_data;
  logic              pred_ready;
  logic              res_valid;
  logic [PC_W-1:0]   res_pc;
  logic              res_taken;
  logic              req_valid;
  logic [PC_W-1:0]   req_addr;
  logic              line_ready;
  logic              pred_valid;
  logic [PC_W-1:0]   pred_fetch_pc;
  logic [PC_W-1:0]   pred_next_pc;
  logic [2:0]        pred_len;
  br_kind_e          pred_kind;

  logic [31:0]       lcg_state = 32'h78cb_1991;
  logic [31:0]       prog [logic [PC_W-1:0]]; // word address -> instruction
  logic [PC_W-1:0]   line_q [$];              // requested lines not yet returned
  int                delay;
  logic              pause;                   // hold req_ready low
  int                errors;
  int                checks;
  int                pred_count;

  // reference model state
  logic [GHR_K-1:0]  m_ghr;
  logic [1:0]        m_cnt [2**IDX_W];
  logic [PC_W-1:0]   m_stack [$];
  logic [PC_W-1:0]   exp_pc;
  logic [PC_W-1:0]   exp_next;
  logic [2:0]        exp_len;
  br_kind_e          exp_kind;
  logic [PC_W-1:0]   exp_push;

  branch_pred_top #(.SLOTS(SLOTS), .GHR_K(GHR_K), .PHT_N(PHT_N), .RAS_DEPTH(RAS_DEPTH)) UUT (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .req_ready(req_ready), .line_valid(line_valid), .line_data(line_data),
    .pred_ready(pred_ready), .res_valid(res_valid), .res_pc(res_pc), .res_taken(res_taken),
    .req_valid(req_valid), .req_addr(req_addr), .line_ready(line_ready),
    .pred_valid(pred_valid), .pred_fetch_pc(pred_fetch_pc), .pred_next_pc(pred_next_pc),
    .pred_len(pred_len), .pred_kind(pred_kind)
  );

  always #5 clk_in = ~clk_in;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // filler is an ADD-class word, never a branch, and varies with the whole address
  function automatic logic [31:0] word_at(logic [PC_W-1:0] a);
    if (prog.exists(a)) return prog[a];
    return {8'h8b, a[25:2] ^ a[49:26] ^ {10'b0, a[63:50]}};
  endfunction

  function automatic logic [31:0] enc_b(logic [PC_W-1:0] off);
    return {6'b000101, off[27:2]};
  endfunction

  function automatic logic [31:0] enc_bl(logic [PC_W-1:0] off);
    return {6'b100101, off[27:2]};
  endfunction

  function automatic logic [31:0] enc_bcond(logic [PC_W-1:0] off);
    return {8'h54, off[20:2], 5'b00000}; // cond EQ
  endfunction

  task automatic report_value(string name, logic [PC_W-1:0] got, logic [PC_W-1:0] want);
    errors++;
    $display("ERR %s got %h expected %h", name, got, want);
  endtask

  // expected prediction for the block at exp_pc under the model state
  task automatic compute_block();
    logic [PC_W-1:0] spc;
    logic [31:0]     w;
    logic [PC_W-1:0] tgt;
    br_kind_e        k;
    int              n;
    n = (64 - int'(exp_pc[5:0])) / 4;
    if (n > SLOTS) n = SLOTS;
    exp_len  = 3'(n);
    exp_next = exp_pc + PC_W'(4 * n);
    exp_kind = BR_NONE;
    for (int i = 0; i < n; i++) begin
      spc = exp_pc + PC_W'(4 * i);
      w   = word_at(spc);
      k   = BR_NONE;
      if (w[31:21] == OPC_RET) begin
        k   = BR_RET;
        tgt = (m_stack.size() != 0) ? m_stack[$] : '0;
      end else if (w[31:26] == OPC_B || w[31:26] == OPC_BL) begin
        k   = (w[31:26] == OPC_B) ? BR_B : BR_BL;
        tgt = spc + {{36{w[25]}}, w[25:0], 2'b00};
      end else if (w[31:24] == OPC_BCOND &&
                   m_cnt[{m_ghr, spc[PHT_N+1:2]}] >= 2'd2) begin
        k   = BR_COND;
        tgt = spc + {{43{w[23]}}, w[23:5], 2'b00};
      end
      if (k != BR_NONE) begin
        exp_len  = 3'(i + 1);
        exp_next = tgt;
        exp_kind = k;
        exp_push = spc + PC_W'(4);
        break;
      end
    end
  endtask

  // reference model, follows the same edges as the DUT
  always @(posedge clk_in) begin
    logic [IDX_W-1:0] idx;
    if (rst_N_in) begin
      m_ghr = '0;
      foreach (m_cnt[i]) m_cnt[i] = 2'd0;
      m_stack.delete();
      exp_pc = '0;
      compute_block();
    end else begin
      if (pred_valid && pred_ready) begin
        pred_count++;
        checks++;
        if (exp_kind == BR_BL) begin
          m_stack.push_back(exp_push);
          if (m_stack.size() > RAS_DEPTH) void'(m_stack.pop_front()); // oldest lost
        end else if (exp_kind == BR_RET && m_stack.size() != 0) begin
          void'(m_stack.pop_back());
        end
        exp_pc = exp_next;
      end
      if (res_valid) begin
        idx = {m_ghr, res_pc[PHT_N+1:2]};
        if (res_taken && m_cnt[idx] != 2'd3) m_cnt[idx] = m_cnt[idx] + 2'd1;
        if (!res_taken && m_cnt[idx] != 2'd0) m_cnt[idx] = m_cnt[idx] - 2'd1;
        m_ghr = {m_ghr[GHR_K-2:0], res_taken};
      end
      if (redirect_valid) exp_pc = redirect_pc; // redirect wins
      compute_block();
    end
  end

  // memory responder and random back-pressure
  always @(posedge clk_in) begin
    logic [PC_W-1:0] base;
    if (rst_N_in) begin
      line_q.delete();
      delay      = 1;
      req_ready  <= 1'b0;
      line_valid <= 1'b0;
      pred_ready <= 1'b0;
    end else begin
      if (req_valid && req_ready) line_q.push_back({req_addr[PC_W-1:6], 6'b0});
      if (line_valid && line_ready) begin
        line_valid <= 1'b0;
        void'(line_q.pop_front());
        delay = 1 + int'(next_rand() >> 20) % 4;
      end else if (!line_valid && line_q.size() != 0) begin
        if (delay <= 1) begin
          base = line_q[0];
          for (int b = 0; b < 16; b++) line_data[32*b +: 32] <= word_at(base + PC_W'(4 * b));
          line_valid <= 1'b1;
        end else begin
          delay--;
        end
      end
      req_ready  <= !pause && (next_rand() >> 18) % 3 != 0;
      pred_ready <= (next_rand() >> 17) % 4 != 0;
    end
  end

  a_fetch_pc : assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid && pred_ready |-> pred_fetch_pc == exp_pc)
    else report_value("pred_fetch_pc", $sampled(pred_fetch_pc), $sampled(exp_pc));
  a_next_pc : assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid && pred_ready |-> pred_next_pc == exp_next)
    else report_value("pred_next_pc", $sampled(pred_next_pc), $sampled(exp_next));
  a_len : assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid && pred_ready |-> pred_len == exp_len)
    else report_value("pred_len", PC_W'($sampled(pred_len)), PC_W'($sampled(exp_len)));
  a_kind : assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid && pred_ready |-> pred_kind == exp_kind)
    else report_value("pred_kind", PC_W'($sampled(pred_kind)), PC_W'($sampled(exp_kind)));
  a_hold : assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid && !pred_ready && !redirect_valid |=>
      pred_valid && $stable({pred_fetch_pc, pred_next_pc, pred_len, pred_kind}))
    else begin
      errors++;
      $display("prediction changed or vanished while waiting for pred_ready");
    end
  a_req_hold : assert property (@(posedge clk_in) disable iff (rst_N_in)
    req_valid && !req_ready && !redirect_valid |=> req_valid && $stable(req_addr))
    else begin
      errors++;
      $display("request address changed or request withdrawn before req_ready");
    end
  a_flush : assert property (@(posedge clk_in) disable iff (rst_N_in)
    redirect_valid |=> !pred_valid)
    else begin
      errors++;
      $display("prediction still valid on the edge after a redirect");
    end

  task automatic send_redirect(logic [PC_W-1:0] pc);
    @(posedge clk_in);
    redirect_valid <= 1'b1;
    redirect_pc    <= pc;
    @(posedge clk_in);
    redirect_valid <= 1'b0;
  endtask

  task automatic wait_preds(int n);
    int target;
    target = pred_count + n;
    wait (pred_count >= target);
    @(posedge clk_in);
  endtask

  task automatic train_taken(logic [PC_W-1:0] pc, int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_in);
      res_valid <= 1'b1;
      res_pc    <= pc;
      res_taken <= 1'b1;
    end
    @(posedge clk_in);
    res_valid <= 1'b0;
  endtask

  initial begin
    clk_in         = 1'b0;
    rst_N_in       = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    req_ready      = 1'b0;
    line_valid     = 1'b0;
    line_data      = '0;
    pred_ready     = 1'b0;
    res_valid      = 1'b0;
    res_pc         = '0;
    res_taken      = 1'b0;
    pause          = 1'b0;
    errors         = 0;
    checks         = 0;
    pred_count     = 0;
    // program: branches at known slots, the rest is filler
    prog[64'h2008] = enc_b(64'h100);
    prog[64'h3008] = enc_bl(-64'sd2048);     // backward call
    prog[64'h4000] = enc_bl(64'h1000);       // nested calls 4000 -> 5000 -> 6000
    prog[64'h5000] = enc_bl(64'h1000);
    prog[64'h6000] = 32'hd65f03c0;           // ret
    prog[64'h5004] = 32'hd65f03c0;
    prog[64'h7004] = enc_bcond(64'h40);
    prog[64'h8000] = enc_b(64'h200);         // shows up at 9000 only if the stale line is used
    repeat (8) @(posedge clk_in);
    rst_N_in <= 1'b0;

    send_redirect(64'h1000);  // straight line, offset 0
    wait_preds(2);
    send_redirect(64'h1038);  // offset 56, two slots left
    wait_preds(2);
    send_redirect(64'h2000);  // B in slot 2
    wait_preds(2);
    send_redirect(64'h3000);  // BL in slot 2, negative offset
    wait_preds(2);
    send_redirect(64'h4000);  // call, call, ret, ret
    wait_preds(5);
    send_redirect(64'h7000);  // B.cond cold, not taken
    wait_preds(2);
    pause <= 1'b1;
    repeat (2) @(posedge clk_in);
    send_redirect(64'h7000);
    train_taken(64'h7004, 12); // history saturates, then the counter
    pause <= 1'b0;
    wait_preds(2);
    send_redirect(64'h8000);  // redirect with a line outstanding
    do @(negedge clk_in); while (!(req_valid && req_ready));
    send_redirect(64'h9000);  // lands while the 8000 line is still owed
    wait_preds(3);
    send_redirect(64'ha000);  // long run under random pred_ready
    wait_preds(20);

    $display("checks %0d errors %0d predictions %0d", checks, errors, pred_count);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog, sized from the planned predictions
  initial begin
    #((BLOCKS * 400 + 1000) * 10);
    $display("timeout, predictions stopped arriving after %0d", pred_count);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: verilog/bp_pkg.sv
/* shared widths, line geometry and branch encodings of the fetch predictor
   only the four direct/return A64 forms below are recognized */
package bp_pkg;

  localparam int PC_W       = 64;             // virtual address width
  localparam int INSTR_W    = 32;             // fixed-length A64 words
  localparam int LINE_BYTES = 64;             // one cache line
  localparam int LINE_W     = LINE_BYTES * 8; // 512-bit line bus
  localparam int OFF_W      = $clog2(LINE_BYTES);

  // kind of the branch that closes a block
  typedef enum logic [2:0] {
    BR_NONE = 3'd0, // fell through to the end of the block
    BR_B    = 3'd1,
    BR_BL   = 3'd2,
    BR_RET  = 3'd3,
    BR_COND = 3'd4
  } br_kind_e;

  // opcode fields, compared against the top bits of the word
  localparam logic [10:0] OPC_RET   = 11'b11010110010; // bits 31:21
  localparam logic [5:0]  OPC_B     = 6'b000101;       // bits 31:26
  localparam logic [5:0]  OPC_BL    = 6'b100101;       // bits 31:26
  localparam logic [7:0]  OPC_BCOND = 8'b01010100;     // bits 31:24

endpackage

// File: verilog/branch_pred_top.sv
`timescale 1ns/1ps
/* fetch branch predictor, one prediction per fetch block. starts on the first
   redirect. history and return stack are not repaired after a mispredict */
module branch_pred_top
  import bp_pkg::*;
#(
  parameter int SLOTS     = 4, // instruction slots per block, at most 7
  parameter int GHR_K     = 8,
  parameter int PHT_N     = 6,
  parameter int RAS_DEPTH = 8
) (
  input  logic              clk_in,
  input  logic              rst_N_in,
  input  logic              redirect_valid,
  input  logic [PC_W-1:0]   redirect_pc,
  input  logic              req_ready,
  input  logic              line_valid,
  input  logic [LINE_W-1:0] line_data,
  input  logic              pred_ready,
  input  logic              res_valid,
  input  logic [PC_W-1:0]   res_pc,
  input  logic              res_taken,
  output logic              req_valid,
  output logic [PC_W-1:0]   req_addr,
  output logic              line_ready,
  output logic              pred_valid,
  output logic [PC_W-1:0]   pred_fetch_pc,
  output logic [PC_W-1:0]   pred_next_pc,
  output logic [2:0]        pred_len,
  output br_kind_e          pred_kind
);

  logic             block_valid;
  logic             advance;
  logic             push;
  logic             pop;
  logic [PC_W-1:0]  fetch_pc;
  logic [PC_W-1:0]  next_pc;
  logic [PC_W-1:0]  push_addr;
  logic [PC_W-1:0]  ras_top;
  logic [SLOTS-1:0] taken_mask;

  slot_if #(.PC_W(PC_W)) slot_bus [SLOTS] ();

  fetch_block_aligner #(.SLOTS(SLOTS), .PC_W(PC_W)) u_align (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .req_ready(req_ready), .line_valid(line_valid), .line_data(line_data),
    .advance(advance), .next_pc(next_pc),
    .req_valid(req_valid), .req_addr(req_addr), .line_ready(line_ready),
    .block_valid(block_valid), .fetch_pc(fetch_pc),
    .slots(slot_bus)
  );

  gshare_predictor #(.SLOTS(SLOTS), .GHR_K(GHR_K), .PHT_N(PHT_N)) u_gshare (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .fetch_pc(fetch_pc),
    .res_valid(res_valid), .res_pc(res_pc), .res_taken(res_taken),
    .taken_mask(taken_mask)
  );

  return_stack #(.RAS_DEPTH(RAS_DEPTH), .PC_W(PC_W)) u_ras (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .push(push), .pop(pop), .push_addr(push_addr),
    .ras_top(ras_top)
  );

  // one predecoder per slot, all share the same return-stack top
  for (genvar i = 0; i < SLOTS; i++) begin : g_pdec
    slot_predecoder #(.PC_W(PC_W)) u_pdec (
      .slot(slot_bus[i]),
      .pred_taken(taken_mask[i]),
      .ras_top(ras_top)
    );
  end

  next_pc_select #(.SLOTS(SLOTS), .PC_W(PC_W)) u_select (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .redirect_valid(redirect_valid), .block_valid(block_valid),
    .fetch_pc(fetch_pc), .pred_ready(pred_ready),
    .slots(slot_bus),
    .advance(advance), .next_pc(next_pc),
    .pred_valid(pred_valid), .pred_fetch_pc(pred_fetch_pc),
    .pred_next_pc(pred_next_pc), .pred_len(pred_len), .pred_kind(pred_kind),
    .push(push), .pop(pop), .push_addr(push_addr)
  );

endmodule

// File: verilog/fetch_block_aligner.sv
`timescale 1ns/1ps
/* idle after reset until the first redirect. lines must come back in request order
   and at most three orphaned lines may be owed at once. SLOTS <= 16 */
module fetch_block_aligner
  import bp_pkg::*;
#(
  parameter int SLOTS = 4,
  parameter int PC_W  = 64
) (
  input  logic              clk_in,
  input  logic              rst_N_in,
  input  logic              redirect_valid,
  input  logic [PC_W-1:0]   redirect_pc,
  input  logic              req_ready,
  input  logic              line_valid,
  input  logic [LINE_W-1:0] line_data,
  input  logic              advance,
  input  logic [PC_W-1:0]   next_pc,
  output logic              req_valid,
  output logic [PC_W-1:0]   req_addr,
  output logic              line_ready,
  output logic              block_valid,
  output logic [PC_W-1:0]   fetch_pc,
  slot_if.align             slots [SLOTS]
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT, HOLD} state_e;

  state_e            state;
  logic [1:0]        drop_cnt;   // lines still owed for requests a redirect orphaned
  logic [LINE_W-1:0] line_q;     // latched line of the current block
  logic [LINE_W-1:0] line_shift; // line moved down so the fetch byte sits at bit 0
  logic [OFF_W-1:0]  off;
  logic              req_xfer;
  logic              line_xfer;
  logic              line_drop;
  logic              line_keep;
  logic              orphan;     // a live request would become stale on a redirect now

  // hold requests back only when the drop counter cannot take another orphan
  assign req_valid   = (state == REQ) && (drop_cnt != 2'd3);
  assign req_addr    = fetch_pc;
  assign line_ready  = (state == WAIT) || (drop_cnt != 2'd0); // stale lines drain anytime
  assign block_valid = (state == HOLD);

  assign req_xfer  = req_valid && req_ready;
  assign line_xfer = line_valid && line_ready;
  assign line_drop = line_xfer && (drop_cnt != 2'd0); // oldest owed line is stale
  assign line_keep = line_xfer && (drop_cnt == 2'd0);
  assign orphan    = ((state == WAIT) && !line_keep) || ((state == REQ) && req_xfer);

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      state    <= IDLE;
      drop_cnt <= 2'd0;
      fetch_pc <= '0;
    end else begin
      drop_cnt <= drop_cnt - 2'(line_drop) + 2'(redirect_valid && orphan);
      if (redirect_valid) begin // wins over every other event
        state    <= REQ;
        fetch_pc <= redirect_pc;
      end else begin
        case (state)
          REQ:  if (req_xfer) state <= WAIT;
          WAIT: if (line_keep) state <= HOLD;
          HOLD: begin
            if (advance) begin // block taken by the selector, go for the next one
              state    <= REQ;
              fetch_pc <= next_pc;
            end
          end
          default: state <= IDLE; // IDLE waits for a redirect
        endcase
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (line_keep) line_q <= line_data;
  end

  assign off        = fetch_pc[OFF_W-1:0];
  assign line_shift = line_q >> {off, 3'b000}; // byte offset to bit offset

  for (genvar i = 0; i < SLOTS; i++) begin : g_slot
    assign slots[i].slot_valid = block_valid && (int'(off) + 4 * i < LINE_BYTES);
    assign slots[i].slot_pc    = fetch_pc + PC_W'(4 * i);
    assign slots[i].slot_instr = line_shift[INSTR_W*i +: INSTR_W]; // little-endian word
  end

  // an offered request keeps its address until taken, unless a redirect replaces it
  a_req_stable : assert property (@(posedge clk_in) disable iff (rst_N_in)
    req_valid && !req_ready && !redirect_valid |=> req_valid && $stable(req_addr))
    else $error("req_addr changed while req_valid waited for req_ready");

endmodule

// File: verilog/gshare_predictor.sv
`timescale 1ns/1ps
/* gshare direction table, index is {ghr, pc[PHT_N+1:2]}. history only moves on
   resolves from execute, nothing is updated speculatively */
module gshare_predictor
  import bp_pkg::*;
#(
  parameter int SLOTS = 4,
  parameter int GHR_K = 8,
  parameter int PHT_N = 6
) (
  input  logic             clk_in,
  input  logic             rst_N_in,
  input  logic [PC_W-1:0]  fetch_pc,
  input  logic             res_valid,
  input  logic [PC_W-1:0]  res_pc,
  input  logic             res_taken,
  output logic [SLOTS-1:0] taken_mask
);

  localparam int IDX_W = GHR_K + PHT_N;

  logic [GHR_K-1:0] ghr;
  logic [1:0]       pht [2**IDX_W]; // saturating counters, >= 2 means taken
  logic [IDX_W-1:0] res_idx;

  // slot i sits 4*i bytes on, so its pc index is the fetch index plus i
  for (genvar i = 0; i < SLOTS; i++) begin : g_lookup
    logic [PHT_N-1:0] pc_idx;
    assign pc_idx        = fetch_pc[PHT_N+1:2] + PHT_N'(i);
    assign taken_mask[i] = pht[{ghr, pc_idx}][1];
  end

  assign res_idx = {ghr, res_pc[PHT_N+1:2]};

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr <= '0;
      pht <= '{default: 2'b00};
    end else if (res_valid) begin
      if (res_taken && pht[res_idx] != 2'b11) begin
        pht[res_idx] <= pht[res_idx] + 2'b01;
      end else if (!res_taken && pht[res_idx] != 2'b00) begin
        pht[res_idx] <= pht[res_idx] - 2'b01;
      end
      ghr <= {ghr[GHR_K-2:0], res_taken}; // newest outcome in bit 0
    end
  end

endmodule

// File: verilog/next_pc_select.sv
`timescale 1ns/1ps
/* picks the first redirecting slot and holds one prediction for the consumer.
   pred_len is 3 bits, so SLOTS <= 7 */
module next_pc_select
  import bp_pkg::*;
#(
  parameter int SLOTS = 4,
  parameter int PC_W  = 64
) (
  input  logic            clk_in,
  input  logic            rst_N_in,
  input  logic            redirect_valid,
  input  logic            block_valid,
  input  logic [PC_W-1:0] fetch_pc,
  input  logic            pred_ready,
  slot_if.select          slots [SLOTS],
  output logic            advance,
  output logic [PC_W-1:0] next_pc,
  output logic            pred_valid,
  output logic [PC_W-1:0] pred_fetch_pc,
  output logic [PC_W-1:0] pred_next_pc,
  output logic [2:0]      pred_len,
  output br_kind_e        pred_kind,
  output logic            push,
  output logic            pop,
  output logic [PC_W-1:0] push_addr
);

  logic [SLOTS-1:0] s_valid;
  logic [SLOTS-1:0] s_redir;
  logic [PC_W-1:0]  s_pc     [SLOTS];
  logic [PC_W-1:0]  s_target [SLOTS];
  br_kind_e         s_kind   [SLOTS];
  logic [2:0]       len;
  br_kind_e         kind;
  logic [PC_W-1:0]  end_pc;    // pc of the slot that closes the block
  logic             pred_xfer;

  for (genvar i = 0; i < SLOTS; i++) begin : g_unpack
    assign s_valid[i]  = slots[i].slot_valid;
    assign s_redir[i]  = slots[i].redirect;
    assign s_pc[i]     = slots[i].slot_pc;
    assign s_target[i] = slots[i].target;
    assign s_kind[i]   = slots[i].kind;
  end

  always_comb begin
    len = 3'd0;
    for (int i = 0; i < SLOTS; i++) begin
      if (s_valid[i]) len = len + 3'd1; // valid slots are contiguous from slot 0
    end
    next_pc = fetch_pc + PC_W'({len, 2'b00}); // fall through past the block
    kind    = BR_NONE;
    end_pc  = fetch_pc;
    // walk down so the lowest redirecting slot wins
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (s_redir[i]) begin
        next_pc = s_target[i];
        len     = 3'(i + 1);
        kind    = s_kind[i];
        end_pc  = s_pc[i];
      end
    end
  end

  assign pred_xfer = pred_valid && pred_ready;
  // take the block when the register is empty or draining this edge
  assign advance   = block_valid && (!pred_valid || pred_ready) && !redirect_valid;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      pred_valid <= 1'b0;
    end else if (redirect_valid) begin
      pred_valid <= 1'b0; // wrong-path prediction is thrown away
    end else if (advance) begin
      pred_valid <= 1'b1;
    end else if (pred_ready) begin
      pred_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (advance) begin
      pred_fetch_pc <= fetch_pc;
      pred_next_pc  <= next_pc;
      pred_len      <= len;
      pred_kind     <= kind;
      push_addr     <= end_pc + PC_W'(4); // return address of a BL
    end
  end

  // call/return bookkeeping only once the consumer has taken the prediction
  assign push = pred_xfer && (pred_kind == BR_BL);
  assign pop  = pred_xfer && (pred_kind == BR_RET);

  a_pred_hold : assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid && !pred_ready && !redirect_valid |=>
      pred_valid && $stable({pred_fetch_pc, pred_next_pc, pred_len, pred_kind}))
    else $error("prediction changed while pred_valid waited for pred_ready");

endmodule

// File: verilog/return_stack.sv
`timescale 1ns/1ps
/* circular return stack, a push when full drops the oldest entry. RAS_DEPTH is a
   power of two, >= 2. ras_top already reflects a push or pop issued this cycle */
module return_stack #(
  parameter int RAS_DEPTH = 8,
  parameter int PC_W      = 64
) (
  input  logic            clk_in,
  input  logic            rst_N_in,
  input  logic            push,
  input  logic            pop,
  input  logic [PC_W-1:0] push_addr,
  output logic [PC_W-1:0] ras_top
);

  localparam int PTR_W = $clog2(RAS_DEPTH);

  logic [PC_W-1:0]  mem [RAS_DEPTH];
  logic [PTR_W-1:0] ptr;   // next free entry
  logic [PTR_W:0]   count; // live entries, saturates at RAS_DEPTH

  // bypass the pending update so a block loaded on the same edge sees it
  always_comb begin
    if (push) begin
      ras_top = push_addr;
    end else if (pop) begin
      ras_top = (count > (PTR_W+1)'(1)) ? mem[ptr - PTR_W'(2)] : '0;
    end else begin
      ras_top = (count != '0) ? mem[ptr - PTR_W'(1)] : '0; // empty reads zero
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ptr   <= '0;
      count <= '0;
    end else if (push) begin
      ptr <= ptr + PTR_W'(1); // wraps over the oldest entry
      if (count != (PTR_W+1)'(RAS_DEPTH)) count <= count + (PTR_W+1)'(1);
    end else if (pop && count != '0) begin
      ptr   <= ptr - PTR_W'(1);
      count <= count - (PTR_W+1)'(1);
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) mem[ptr] <= push_addr;
  end

  // one prediction ends in a single branch, so the selector never asks for both
  a_push_pop : assert property (@(posedge clk_in) disable iff (rst_N_in) !(push && pop))
    else $error("return stack push and pop in the same cycle");

endmodule

// File: verilog/slot_if.sv
`timescale 1ns/1ps
/* one instruction slot on its way from aligner through predecoder to the selector */
interface slot_if
  import bp_pkg::*;
#(
  parameter int PC_W = 64
) ();

  logic               slot_valid; // slot lies inside the fetched line
  logic [PC_W-1:0]    slot_pc;
  logic [INSTR_W-1:0] slot_instr;
  br_kind_e           kind;
  logic [PC_W-1:0]    target;
  logic               redirect;   // this slot ends the block

  modport align  (output slot_valid, slot_pc, slot_instr);
  modport decode (input slot_valid, slot_pc, slot_instr,
                  output kind, target, redirect);
  modport select (input slot_valid, slot_pc, kind, target, redirect);

endinterface

// File: verilog/slot_predecoder.sv
`timescale 1ns/1ps
/* classifies one slot as B, BL, RET or B.cond, anything else falls through.
   RET takes the return-stack top, zero when the stack is empty */
module slot_predecoder
  import bp_pkg::*;
#(
  parameter int PC_W = 64
) (
  slot_if.decode     slot,
  input logic        pred_taken, // direction from the gshare table
  input logic [PC_W-1:0] ras_top
);

  logic [INSTR_W-1:0] instr;
  logic [PC_W-1:0]    off_imm26; // B / BL byte offset
  logic [PC_W-1:0]    off_imm19; // B.cond byte offset
  logic               is_ret;
  logic               is_b;
  logic               is_bl;
  logic               is_bcond;
  br_kind_e           kind;
  logic [PC_W-1:0]    target;

  assign instr    = slot.slot_instr;
  assign is_ret   = (instr[31:21] == OPC_RET);
  assign is_b     = (instr[31:26] == OPC_B);
  assign is_bl    = (instr[31:26] == OPC_BL);
  assign is_bcond = (instr[31:24] == OPC_BCOND);

  // sign extend and scale by 4
  assign off_imm26 = {{(PC_W-28){instr[25]}}, instr[25:0], 2'b00};
  assign off_imm19 = {{(PC_W-21){instr[23]}}, instr[23:5], 2'b00};

  always_comb begin
    kind   = BR_NONE;
    target = slot.slot_pc + PC_W'(4); // sequential successor
    if (slot.slot_valid) begin
      if (is_ret) begin
        kind   = BR_RET;
        target = ras_top;
      end else if (is_b) begin
        kind   = BR_B;
        target = slot.slot_pc + off_imm26;
      end else if (is_bl) begin
        kind   = BR_BL;
        target = slot.slot_pc + off_imm26;
      end else if (is_bcond) begin
        kind   = BR_COND;
        target = slot.slot_pc + off_imm19;
      end
    end
  end

  assign slot.kind     = kind;
  assign slot.target   = target;
  // unconditional forms always leave the block, B.cond only when predicted taken
  assign slot.redirect = (kind == BR_B) || (kind == BR_BL) || (kind == BR_RET) ||
                         ((kind == BR_COND) && pred_taken);

endmodule
